// ==== hw/warp_sched_pkg.sv ====
// warp scheduler package with sizes, command opcodes and the issue payload
package warp_sched_pkg;

    localparam int num_warps = 4;
    localparam int nw_width = 2;
    localparam int num_threads = 4;
    localparam int pc_width = 32;
    localparam int num_barriers = 2;
    localparam int nb_width = 1;
    localparam int pending_width = 6;

    // warp control opcodes
    typedef enum logic [1:0] {
        op_wspawn = 2'd0,
        op_tmc    = 2'd1,
        op_bar    = 2'd2,
        op_none   = 2'd3
    } ctl_op_t;

    // what goes downstream per issue, 38 bits
    typedef struct packed {
        logic [nw_width-1:0]    wid;
        logic [num_threads-1:0] tmask;
        logic [pc_width-1:0]    pc;
    } issue_t;

endpackage

// ==== hw/warp_ctl_if.sv ====
// warp control interface carrying decoded state updates to the warp table
`timescale 1ns/1ns

interface warp_ctl_if;
    logic                                   spawn_valid;
    logic [warp_sched_pkg::num_warps-1:0]   spawn_mask;
    logic [warp_sched_pkg::pc_width-1:0]    spawn_pc;
    logic                                   tmc_valid;
    logic [warp_sched_pkg::nw_width-1:0]    tmc_wid;
    logic [warp_sched_pkg::num_threads-1:0] tmc_mask;
    logic                                   bar_stall_valid;
    logic [warp_sched_pkg::nw_width-1:0]    bar_wid;
    logic [warp_sched_pkg::num_warps-1:0]   bar_release_mask;
    logic                                   unlock_valid;
    logic [warp_sched_pkg::nw_width-1:0]    unlock_wid;
    logic                                   branch_valid;
    logic [warp_sched_pkg::nw_width-1:0]    branch_wid;
    logic                                   branch_taken;
    logic [warp_sched_pkg::pc_width-1:0]    branch_dest;

    modport src (
        output spawn_valid, spawn_mask, spawn_pc, tmc_valid, tmc_wid, tmc_mask,
        output bar_stall_valid, bar_wid, bar_release_mask, unlock_valid, unlock_wid,
        output branch_valid, branch_wid, branch_taken, branch_dest
    );
    modport dst (
        input spawn_valid, spawn_mask, spawn_pc, tmc_valid, tmc_wid, tmc_mask,
        input bar_stall_valid, bar_wid, bar_release_mask, unlock_valid, unlock_wid,
        input branch_valid, branch_wid, branch_taken, branch_dest
    );
endinterface

// ==== hw/issue_if.sv ====
// issue interface carrying the selected warp into the issue buffer
`timescale 1ns/1ns

interface issue_if;
    logic                   valid;
    logic                   ready;
    warp_sched_pkg::issue_t data;

    // transfer when valid and ready meet at a rising edge
    modport src (
        output valid, data,
        input  ready
    );
    modport dst (
        input  valid, data,
        output ready
    );
endinterface

// ==== hw/warp_ctl_decode.sv ====
// warp control decode, registers command strobes and tracks local barriers
`timescale 1ns/1ns

module warp_ctl_decode (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   ctl_valid,
    input  warp_sched_pkg::ctl_op_t                ctl_op,
    input  logic [warp_sched_pkg::nw_width-1:0]    ctl_wid,
    input  logic [warp_sched_pkg::num_threads-1:0] ctl_mask,
    input  logic [warp_sched_pkg::pc_width-1:0]    ctl_pc,
    input  logic [warp_sched_pkg::nb_width-1:0]    ctl_bar_id,
    input  logic [warp_sched_pkg::nw_width-1:0]    ctl_bar_size_m1,
    input  logic                                   unlock_valid,
    input  logic [warp_sched_pkg::nw_width-1:0]    unlock_wid,
    input  logic                                   branch_valid,
    input  logic [warp_sched_pkg::nw_width-1:0]    branch_wid,
    input  logic                                   branch_taken,
    input  logic [warp_sched_pkg::pc_width-1:0]    branch_dest,
    warp_ctl_if.src                                upd
);
    // one arrival mask per barrier id
    logic [warp_sched_pkg::num_barriers-1:0][warp_sched_pkg::num_warps-1:0] bar_masks;
    logic [warp_sched_pkg::num_warps-1:0] cur_mask;
    logic [warp_sched_pkg::nw_width:0]    arrive_cnt;
    logic                                 is_bar;
    logic                                 bar_last;

    assign cur_mask = bar_masks[ctl_bar_id];
    assign is_bar = ctl_valid && (ctl_op == warp_sched_pkg::op_bar);

    always_comb begin
        arrive_cnt = '0;
        for (int i = 0; i < warp_sched_pkg::num_warps; i++) begin
            arrive_cnt = arrive_cnt + (warp_sched_pkg::nw_width + 1)'(cur_mask[i]);
        end
    end

    // final arrival when everyone else is already waiting
    assign bar_last = (arrive_cnt == {1'b0, ctl_bar_size_m1});

    always_ff @(posedge clk) begin
        if (reset) begin
            bar_masks            <= '0;
            upd.spawn_valid      <= 1'b0;
            upd.tmc_valid        <= 1'b0;
            upd.bar_stall_valid  <= 1'b0;
            upd.bar_release_mask <= '0;
            upd.unlock_valid     <= 1'b0;
            upd.branch_valid     <= 1'b0;
        end else begin
            upd.spawn_valid      <= ctl_valid && (ctl_op == warp_sched_pkg::op_wspawn);
            upd.tmc_valid        <= ctl_valid && (ctl_op == warp_sched_pkg::op_tmc);
            upd.bar_stall_valid  <= is_bar && !bar_last;
            upd.bar_release_mask <= (is_bar && bar_last) ? cur_mask : '0;
            upd.unlock_valid     <= unlock_valid;
            upd.branch_valid     <= branch_valid;
            if (is_bar) begin
                if (bar_last) begin
                    bar_masks[ctl_bar_id] <= '0;
                end else begin
                    bar_masks[ctl_bar_id][ctl_wid] <= 1'b1;
                end
            end
        end
    end

    // payload fields follow their strobes
    always_ff @(posedge clk) begin
        upd.spawn_mask   <= warp_sched_pkg::num_warps'(ctl_mask);
        upd.spawn_pc     <= ctl_pc;
        upd.tmc_wid      <= ctl_wid;
        upd.tmc_mask     <= ctl_mask;
        upd.bar_wid      <= ctl_wid;
        upd.unlock_wid   <= unlock_wid;
        upd.branch_wid   <= branch_wid;
        upd.branch_taken <= branch_taken;
        upd.branch_dest  <= branch_dest;
    end

    a_no_op_none: assert property (@(posedge clk) disable iff (reset)
        ctl_valid |-> (ctl_op != warp_sched_pkg::op_none));

endmodule

// ==== hw/warp_table.sv ====
// warp table holding per-warp state and picking the lowest ready warp
`timescale 1ns/1ns

module warp_table (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [warp_sched_pkg::pc_width-1:0] startup_pc,
    warp_ctl_if.dst                             upd,
    issue_if.src                                sel,
    output logic                                active_any
);
    logic [warp_sched_pkg::num_warps-1:0] active_r, active_n;
    logic [warp_sched_pkg::num_warps-1:0] stalled_r, stalled_n;
    logic [warp_sched_pkg::num_warps-1:0] bar_stall_r, bar_stall_n;
    logic [warp_sched_pkg::num_warps-1:0][warp_sched_pkg::num_threads-1:0] tmask_r, tmask_n;
    logic [warp_sched_pkg::num_warps-1:0][warp_sched_pkg::pc_width-1:0] pc_r, pc_n;
    logic [warp_sched_pkg::num_warps-1:0] ready_warps;
    logic [warp_sched_pkg::nw_width-1:0]  pick_wid;
    logic [warp_sched_pkg::nw_width-1:0]  sel_wid;
    logic [warp_sched_pkg::nw_width-1:0]  hold_wid;
    logic                                 pick_valid;
    logic                                 hold_valid;
    logic                                 sel_fire;

    assign ready_warps = active_r & ~(stalled_r | bar_stall_r);
    assign active_any = |active_r;

    // lowest index wins
    always_comb begin
        pick_valid = 1'b0;
        pick_wid = '0;
        for (int i = warp_sched_pkg::num_warps - 1; i >= 0; i--) begin
            if (ready_warps[i]) begin
                pick_valid = 1'b1;
                pick_wid = warp_sched_pkg::nw_width'(i);
            end
        end
    end

    // keep the offered warp while the buffer pushes back
    assign sel_wid = hold_valid ? hold_wid : pick_wid;
    assign sel.valid = hold_valid || pick_valid;
    assign sel.data.wid = sel_wid;
    assign sel.data.tmask = tmask_r[sel_wid];
    assign sel.data.pc = pc_r[sel_wid];
    assign sel_fire = sel.valid && sel.ready;

    always_comb begin
        active_n = active_r;
        stalled_n = stalled_r;
        bar_stall_n = bar_stall_r;
        tmask_n = tmask_r;
        pc_n = pc_r;

        // spawned warps start fresh with one thread
        if (upd.spawn_valid) begin
            for (int i = 0; i < warp_sched_pkg::num_warps; i++) begin
                if (upd.spawn_mask[i]) begin
                    active_n[i] = 1'b1;
                    stalled_n[i] = 1'b0;
                    bar_stall_n[i] = 1'b0;
                    tmask_n[i] = warp_sched_pkg::num_threads'(1);
                    pc_n[i] = upd.spawn_pc;
                end
            end
        end

        // zero mask retires the warp
        if (upd.tmc_valid) begin
            active_n[upd.tmc_wid] = (upd.tmc_mask != '0);
            tmask_n[upd.tmc_wid] = upd.tmc_mask;
        end

        if (upd.bar_stall_valid) begin
            bar_stall_n[upd.bar_wid] = 1'b1;
        end
        bar_stall_n = bar_stall_n & ~upd.bar_release_mask;

        if (upd.unlock_valid) begin
            stalled_n[upd.unlock_wid] = 1'b0;
        end
        if (upd.branch_valid) begin
            stalled_n[upd.branch_wid] = 1'b0;
        end

        // issued warp waits for unlock or branch
        if (sel_fire) begin
            stalled_n[sel_wid] = 1'b1;
            pc_n[sel_wid] = sel.data.pc + warp_sched_pkg::pc_width'(4);
        end

        // taken branch overrides the pc advance
        if (upd.branch_valid && upd.branch_taken) begin
            pc_n[upd.branch_wid] = upd.branch_dest;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active_r    <= warp_sched_pkg::num_warps'(1);
            stalled_r   <= '0;
            bar_stall_r <= '0;
            tmask_r     <= '0;
            tmask_r[0]  <= warp_sched_pkg::num_threads'(1);
            pc_r        <= '0;
            pc_r[0]     <= startup_pc;
            hold_valid  <= 1'b0;
        end else begin
            active_r    <= active_n;
            stalled_r   <= stalled_n;
            bar_stall_r <= bar_stall_n;
            tmask_r     <= tmask_n;
            pc_r        <= pc_n;
            hold_valid  <= sel.valid && !sel.ready;
        end
    end

    always_ff @(posedge clk) begin
        hold_wid <= sel_wid;
    end

    a_sel_active: assert property (@(posedge clk) disable iff (reset)
        sel.valid |-> active_r[sel_wid]);

    a_tmc_active: assert property (@(posedge clk) disable iff (reset)
        upd.tmc_valid |-> active_r[upd.tmc_wid]);

endmodule

// ==== hw/issue_buffer.sv ====
// issue buffer, two-entry skid on the issue handshake with pending count and busy
`timescale 1ns/1ns

module issue_buffer (
    input  logic                                   clk,
    input  logic                                   reset,
    issue_if.dst                                   sel,
    output logic                                   issue_valid,
    input  logic                                   issue_ready,
    output logic [warp_sched_pkg::nw_width-1:0]    issue_wid,
    output logic [warp_sched_pkg::num_threads-1:0] issue_tmask,
    output logic [warp_sched_pkg::pc_width-1:0]    issue_pc,
    input  logic                                   commit_valid,
    input  logic                                   active_any,
    output logic                                   busy
);
    warp_sched_pkg::issue_t out_data;
    warp_sched_pkg::issue_t skid_data;
    logic                   out_valid;
    logic                   skid_valid;
    logic                   push;
    logic                   pop;
    logic [warp_sched_pkg::pending_width-1:0] pending_cnt;

    // ready only looks at a flop
    assign sel.ready = !skid_valid;
    assign push = sel.valid && sel.ready;
    assign pop = out_valid && issue_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (!out_valid || pop) begin
            if (skid_valid) begin
                out_valid  <= 1'b1;
                skid_valid <= 1'b0;
            end else begin
                out_valid <= push;
            end
        end else if (push) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!out_valid || pop) begin
            out_data <= skid_valid ? skid_data : sel.data;
        end
        if (push && out_valid && !pop) begin
            skid_data <= sel.data;
        end
    end

    assign issue_valid = out_valid;
    assign issue_wid = out_data.wid;
    assign issue_tmask = out_data.tmask;
    assign issue_pc = out_data.pc;

    // outstanding issues waiting for commit
    always_ff @(posedge clk) begin
        if (reset) begin
            pending_cnt <= '0;
            busy        <= 1'b0;
        end else begin
            if (pop && !commit_valid) begin
                pending_cnt <= pending_cnt + 1'b1;
            end else if (commit_valid && !pop) begin
                pending_cnt <= pending_cnt - 1'b1;
            end
            busy <= active_any || (pending_cnt != '0);
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (reset)
        (issue_valid && !issue_ready) |=> (issue_valid && $stable(out_data)));

    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        commit_valid |-> (pending_cnt != '0 || pop));

endmodule

// ==== hw/warp_sched_top.sv ====
// warp scheduler top level wiring command decode, warp table and issue buffer
`timescale 1ns/1ns

module warp_sched_top (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic [warp_sched_pkg::pc_width-1:0]    startup_pc,
    input  logic                                   ctl_valid,
    input  warp_sched_pkg::ctl_op_t                ctl_op,
    input  logic [warp_sched_pkg::nw_width-1:0]    ctl_wid,
    input  logic [warp_sched_pkg::num_threads-1:0] ctl_mask,
    input  logic [warp_sched_pkg::pc_width-1:0]    ctl_pc,
    input  logic [warp_sched_pkg::nb_width-1:0]    ctl_bar_id,
    input  logic [warp_sched_pkg::nw_width-1:0]    ctl_bar_size_m1,
    input  logic                                   unlock_valid,
    input  logic [warp_sched_pkg::nw_width-1:0]    unlock_wid,
    input  logic                                   branch_valid,
    input  logic [warp_sched_pkg::nw_width-1:0]    branch_wid,
    input  logic                                   branch_taken,
    input  logic [warp_sched_pkg::pc_width-1:0]    branch_dest,
    output logic                                   issue_valid,
    input  logic                                   issue_ready,
    output logic [warp_sched_pkg::nw_width-1:0]    issue_wid,
    output logic [warp_sched_pkg::num_threads-1:0] issue_tmask,
    output logic [warp_sched_pkg::pc_width-1:0]    issue_pc,
    input  logic                                   commit_valid,
    output logic                                   busy
);
    logic active_any;

    warp_ctl_if ctl_bus ();
    issue_if    sel_bus ();

    warp_ctl_decode u_decode (
        .clk             (clk),
        .reset           (reset),
        .ctl_valid       (ctl_valid),
        .ctl_op          (ctl_op),
        .ctl_wid         (ctl_wid),
        .ctl_mask        (ctl_mask),
        .ctl_pc          (ctl_pc),
        .ctl_bar_id      (ctl_bar_id),
        .ctl_bar_size_m1 (ctl_bar_size_m1),
        .unlock_valid    (unlock_valid),
        .unlock_wid      (unlock_wid),
        .branch_valid    (branch_valid),
        .branch_wid      (branch_wid),
        .branch_taken    (branch_taken),
        .branch_dest     (branch_dest),
        .upd             (ctl_bus.src)
    );

    warp_table u_table (
        .clk        (clk),
        .reset      (reset),
        .startup_pc (startup_pc),
        .upd        (ctl_bus.dst),
        .sel        (sel_bus.src),
        .active_any (active_any)
    );

    issue_buffer u_buffer (
        .clk          (clk),
        .reset        (reset),
        .sel          (sel_bus.dst),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue_wid    (issue_wid),
        .issue_tmask  (issue_tmask),
        .issue_pc     (issue_pc),
        .commit_valid (commit_valid),
        .active_any   (active_any),
        .busy         (busy)
    );

endmodule

// ==== dv/tb_clock.sv ====
// testbench clock generator with a 40 ns period
`timescale 1ns/1ns

module tb_clock (
    output logic clk
);
    localparam int half_period = 20;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

endmodule

// ==== dv/warp_sched_tb.sv ====
// warp scheduler testbench with a per-warp reference model and checking assertions
`timescale 1ns/1ns

module warp_sched_tb;
    localparam int clk_period = 40;
    localparam int stim_cycles = 1200;
    localparam int drain_limit = 60;

    logic                                   clk;
    logic                                   reset;
    logic [warp_sched_pkg::pc_width-1:0]    startup_pc;
    logic                                   ctl_valid;
    warp_sched_pkg::ctl_op_t                ctl_op;
    logic [warp_sched_pkg::nw_width-1:0]    ctl_wid;
    logic [warp_sched_pkg::num_threads-1:0] ctl_mask;
    logic [warp_sched_pkg::pc_width-1:0]    ctl_pc;
    logic [warp_sched_pkg::nb_width-1:0]    ctl_bar_id;
    logic [warp_sched_pkg::nw_width-1:0]    ctl_bar_size_m1;
    logic                                   unlock_valid;
    logic [warp_sched_pkg::nw_width-1:0]    unlock_wid;
    logic                                   branch_valid;
    logic [warp_sched_pkg::nw_width-1:0]    branch_wid;
    logic                                   branch_taken;
    logic [warp_sched_pkg::pc_width-1:0]    branch_dest;
    logic                                   issue_valid;
    logic                                   issue_ready;
    logic [warp_sched_pkg::nw_width-1:0]    issue_wid;
    logic [warp_sched_pkg::num_threads-1:0] issue_tmask;
    logic [warp_sched_pkg::pc_width-1:0]    issue_pc;
    logic                                   commit_valid;
    logic                                   busy;

    // reference model of per-warp state
    logic [warp_sched_pkg::num_warps-1:0]   m_active;
    logic [warp_sched_pkg::num_warps-1:0]   m_stalled;
    logic [warp_sched_pkg::num_warps-1:0]   m_bar;
    logic [warp_sched_pkg::num_threads-1:0] m_tmask [warp_sched_pkg::num_warps];
    logic [warp_sched_pkg::pc_width-1:0]    m_pc [warp_sched_pkg::num_warps];

    // expected transfer at the coming rising edge
    logic                                   exp_valid;
    logic [warp_sched_pkg::nw_width-1:0]    exp_wid;
    logic [warp_sched_pkg::num_threads-1:0] exp_tmask;
    logic [warp_sched_pkg::pc_width-1:0]    exp_pc;

    int seed;
    int pending;
    int xfer_count;
    int value_errors;
    int flow_errors;
    int proc_errors;
    bit commit_en;
    bit busy_watch;

    tb_clock clock_gen (.clk(clk));

    warp_sched_top dut0 (.*);

    // lowest-index warp that is active and not stalled
    function automatic int pick_ready();
        for (int i = 0; i < warp_sched_pkg::num_warps; i++) begin
            if (m_active[i] && !m_stalled[i] && !m_bar[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic check_busy(input logic want);
        assert (busy == want) else begin
            proc_errors++;
            $display("mismatch at %0t: busy got %b expected %b", $time, busy, want);
        end
    endtask

    // advance to the next falling edge and predict the coming transfer
    task automatic step();
        int w;
        @(negedge clk);
        if (busy_watch && pending > 0) begin
            check_busy(1'b1);
        end
        ctl_valid = 1'b0;
        ctl_op = warp_sched_pkg::op_none;
        unlock_valid = 1'b0;
        branch_valid = 1'b0;
        commit_valid = 1'b0;
        issue_ready = ($random(seed) % 4) != 0;
        if (commit_en && pending > 0 && ($random(seed) % 2) == 0) begin
            commit_valid = 1'b1;
            pending--;
        end
        exp_valid = 1'b0;
        if (issue_valid && issue_ready) begin
            w = pick_ready();
            if (w >= 0) begin
                exp_valid = 1'b1;
                exp_wid = warp_sched_pkg::nw_width'(w);
                exp_tmask = m_tmask[w];
                exp_pc = m_pc[w];
                m_stalled[w] = 1'b1;
                m_pc[w] = m_pc[w] + 32'd4;
                pending++;
                xfer_count++;
            end
        end
    endtask

    task automatic idle(input int n);
        repeat (n) step();
    endtask

    // run until every ready warp of the model has gone out
    task automatic drain();
        int guard;
        guard = 0;
        while (pick_ready() >= 0 && guard < drain_limit) begin
            step();
            guard++;
        end
        if (pick_ready() >= 0) begin
            proc_errors++;
            $display("timeout at %0t waiting for warp %0d to issue", $time, pick_ready());
        end
        idle(2);
    endtask

    task automatic spawn(input logic [warp_sched_pkg::num_warps-1:0] mask,
                         input logic [warp_sched_pkg::pc_width-1:0] pc);
        step();
        ctl_valid = 1'b1;
        ctl_op = warp_sched_pkg::op_wspawn;
        ctl_mask = warp_sched_pkg::num_threads'(mask);
        ctl_pc = pc;
        for (int i = 0; i < warp_sched_pkg::num_warps; i++) begin
            if (mask[i]) begin
                m_active[i] = 1'b1;
                m_stalled[i] = 1'b0;
                m_bar[i] = 1'b0;
                m_tmask[i] = warp_sched_pkg::num_threads'(1);
                m_pc[i] = pc;
            end
        end
    endtask

    task automatic set_tmask(input logic [warp_sched_pkg::nw_width-1:0] w,
                             input logic [warp_sched_pkg::num_threads-1:0] tm);
        step();
        ctl_valid = 1'b1;
        ctl_op = warp_sched_pkg::op_tmc;
        ctl_wid = w;
        ctl_mask = tm;
        m_tmask[w] = tm;
        m_active[w] = (tm != '0);
    endtask

    task automatic unlock(input logic [warp_sched_pkg::nw_width-1:0] w);
        step();
        unlock_valid = 1'b1;
        unlock_wid = w;
        m_stalled[w] = 1'b0;
    endtask

    task automatic branch(input logic [warp_sched_pkg::nw_width-1:0] w, input logic taken,
                          input logic [warp_sched_pkg::pc_width-1:0] dest);
        step();
        branch_valid = 1'b1;
        branch_wid = w;
        branch_taken = taken;
        branch_dest = dest;
        m_stalled[w] = 1'b0;
        if (taken) begin
            m_pc[w] = dest;
        end
    endtask

    // bar command with an unlock in the same cycle
    // the last arrival frees everyone
    task automatic arrive(input logic [warp_sched_pkg::nw_width-1:0] w,
                          input logic [warp_sched_pkg::nb_width-1:0] bid,
                          input int k, input bit last);
        step();
        ctl_valid = 1'b1;
        ctl_op = warp_sched_pkg::op_bar;
        ctl_wid = w;
        ctl_bar_id = bid;
        ctl_bar_size_m1 = warp_sched_pkg::nw_width'(k);
        unlock_valid = 1'b1;
        unlock_wid = w;
        m_stalled[w] = 1'b0;
        if (last) begin
            m_bar = '0;
        end else begin
            m_bar[w] = 1'b1;
        end
    endtask

    a_xfer_expected: assert property (@(posedge clk) disable iff (reset)
        (issue_valid && issue_ready) |-> exp_valid)
        else begin
            flow_errors++;
            $display("unexpected transfer at %0t while no warp of the model is ready", $time);
        end

    a_wid: assert property (@(posedge clk) disable iff (reset)
        (issue_valid && issue_ready && exp_valid) |-> (issue_wid == exp_wid))
        else begin
            value_errors++;
            $display("mismatch at %0t: issue_wid got %0d expected %0d", $time,
                $sampled(issue_wid), $sampled(exp_wid));
        end

    a_tmask: assert property (@(posedge clk) disable iff (reset)
        (issue_valid && issue_ready && exp_valid) |-> (issue_tmask == exp_tmask))
        else begin
            value_errors++;
            $display("mismatch at %0t: issue_tmask got %b expected %b", $time,
                $sampled(issue_tmask), $sampled(exp_tmask));
        end

    a_pc: assert property (@(posedge clk) disable iff (reset)
        (issue_valid && issue_ready && exp_valid) |-> (issue_pc == exp_pc))
        else begin
            value_errors++;
            $display("mismatch at %0t: issue_pc got %h expected %h", $time,
                $sampled(issue_pc), $sampled(exp_pc));
        end

    a_stable: assert property (@(posedge clk) disable iff (reset)
        (issue_valid && !issue_ready) |=> (issue_valid && $stable(issue_wid)
            && $stable(issue_tmask) && $stable(issue_pc)))
        else begin
            flow_errors++;
            $display("issue output changed at %0t while the consumer held it back", $time);
        end

    initial begin
        #(stim_cycles * clk_period * 2);
        $display("watchdog expired at %0t before the tests finished", $time);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        logic [warp_sched_pkg::nw_width-1:0]    w;
        logic [warp_sched_pkg::num_warps-1:0]   m;
        logic [warp_sched_pkg::num_threads-1:0] tm;
        logic [warp_sched_pkg::nb_width-1:0]    bid;
        int k;

        seed = 32'h033f_a174;
        pending = 0;
        xfer_count = 0;
        value_errors = 0;
        flow_errors = 0;
        proc_errors = 0;
        commit_en = 1'b1;
        busy_watch = 1'b0;
        exp_valid = 1'b0;
        exp_wid = '0;
        exp_tmask = '0;
        exp_pc = '0;
        reset = 1'b1;
        startup_pc = {$random(seed)} & 32'hffff_fffc;
        ctl_valid = 1'b0;
        ctl_op = warp_sched_pkg::op_none;
        ctl_wid = '0;
        ctl_mask = '0;
        ctl_pc = '0;
        ctl_bar_id = '0;
        ctl_bar_size_m1 = '0;
        unlock_valid = 1'b0;
        unlock_wid = '0;
        branch_valid = 1'b0;
        branch_wid = '0;
        branch_taken = 1'b0;
        branch_dest = '0;
        issue_ready = 1'b1;
        commit_valid = 1'b0;

        // warp 0 comes out of reset at startup_pc
        m_active = warp_sched_pkg::num_warps'(1);
        m_stalled = '0;
        m_bar = '0;
        for (int i = 0; i < warp_sched_pkg::num_warps; i++) begin
            m_tmask[i] = '0;
            m_pc[i] = '0;
        end
        m_tmask[0] = warp_sched_pkg::num_threads'(1);
        m_pc[0] = startup_pc;

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_busy(1'b0);
        assert (!issue_valid) else begin
            proc_errors++;
            $display("issue_valid is high right after reset at %0t", $time);
        end

        // first issue, then unlock, taken and not-taken branch
        drain();
        check_busy(1'b1);
        idle(6);
        unlock('0);
        drain();
        branch('0, 1'b1, {$random(seed)} & 32'hffff_fffc);
        drain();
        branch('0, 1'b0, {$random(seed)} & 32'hffff_fffc);
        drain();

        // random spawns, then random releases of active warps
        repeat (3) begin
            m = warp_sched_pkg::num_warps'($random(seed));
            if (m == '0) begin
                m = warp_sched_pkg::num_warps'(2);
            end
            spawn(m, {$random(seed)} & 32'hffff_fffc);
            drain();
        end
        repeat (12) begin
            w = warp_sched_pkg::nw_width'($random(seed));
            while (!m_active[w]) begin
                w = w + 1'b1;
            end
            if (($random(seed) % 2) == 0) begin
                unlock(w);
            end else begin
                branch(w, 1'($random(seed)), {$random(seed)} & 32'hffff_fffc);
            end
            drain();
        end

        // thread mask change, then a zero mask retires the last warp
        spawn('1, {$random(seed)} & 32'hffff_fffc);
        drain();
        w = warp_sched_pkg::nw_width'($random(seed));
        tm = warp_sched_pkg::num_threads'($random(seed));
        if (tm == '0 || tm == warp_sched_pkg::num_threads'(1)) begin
            tm = warp_sched_pkg::num_threads'(8);
        end
        set_tmask(w, tm);
        unlock(w);
        drain();
        set_tmask('1, '0);
        unlock('1);
        drain();
        idle(6);

        // local barrier with k+1 arrivals
        spawn('1, {$random(seed)} & 32'hffff_fffc);
        drain();
        k = 1 + int'({$random(seed)} % 3);
        bid = warp_sched_pkg::nb_width'($random(seed));
        for (int i = 0; i <= k; i++) begin
            arrive(warp_sched_pkg::nw_width'(i), bid, k, i == k);
            if (i < k) begin
                idle(6);
            end else begin
                drain();
            end
        end

        // busy must hold after all warps retire until the last commit
        commit_en = 1'b0;
        unlock('0);
        drain();
        busy_watch = 1'b1;
        for (int i = 0; i < warp_sched_pkg::num_warps; i++) begin
            if (m_active[i]) begin
                set_tmask(warp_sched_pkg::nw_width'(i), '0);
            end
        end
        idle(6);
        commit_en = 1'b1;
        k = 0;
        while (pending > 0 && k < 200) begin
            step();
            k++;
        end
        idle(3);
        busy_watch = 1'b0;
        check_busy(1'b0);

        $display("errors: %0d value, %0d handshake, %0d other, %0d transfers checked",
            value_errors, flow_errors, proc_errors, xfer_count);
        if (value_errors + flow_errors + proc_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== warp_sched.f ====
hw/warp_sched_pkg.sv
hw/warp_ctl_if.sv
hw/issue_if.sv
hw/warp_ctl_decode.sv
hw/warp_table.sv
hw/issue_buffer.sv
hw/warp_sched_top.sv
dv/tb_clock.sv
dv/warp_sched_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module warp_sched_tb -f warp_sched.f

result=$(./obj_dir/Vwarp_sched_tb)
echo "$result"

# fails the script unless the pass line is present
echo "$result" | grep -qF '*** PASSED ***'
